// ==== common/te_ctrl_pkg.sv ====
// engine state encoding, channel counts and state word layout
// shared by the sequencing blocks and the slot accumulators
package te_ctrl_pkg;

	localparam int NUM_LOGIC = 32; // logical channels
	localparam int CH_IDX_W  = 5;  // logical channel index

	// round states, gaps left where the full engine has extra steps
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		START        = 4'd1,
		FIND_CHANNEL = 4'd2,
		FILL_STATE   = 4'd3,
		READ_FIFO    = 4'd5,
		CORRELATION  = 4'd6,
		DUMP_STATE   = 4'd8,
		COR_FINISH   = 4'd9,
		TE_FINISH    = 4'd10,
		WAIT_CPU     = 4'd11,
		STAND_BY     = 4'd12
	} te_state_t;

	//--------------------------------------------------
	// state buffer layout, address = index * 32 + offset
	//--------------------------------------------------
	localparam int WORD_OFS_W = 5;
	localparam int BUF_ADDR_W = CH_IDX_W + WORD_OFS_W;
	localparam logic [WORD_OFS_W-1:0] WORD_SUM    = 5'd0;
	localparam logic [WORD_OFS_W-1:0] WORD_COUNT  = 5'd1;
	localparam logic [WORD_OFS_W-1:0] WORD_TARGET = 5'd2; // blocks per coherent period
	localparam logic [WORD_OFS_W-1:0] WORD_RESULT = 5'd3;

	localparam int COR_TAIL = 5; // cycles from last sample to end of correlation

endpackage

// ==== common/te_reg_pkg.sv ====
// host register map and data widths of the tracking engine
// imported by the register block, the buffer arbiter and the top level
package te_reg_pkg;

	localparam int TE_DATA_W = 32; // host and state buffer word
	localparam int TE_ADDR_W = 10; // host address, covers the whole state buffer
	localparam int REG_OFS_W = 6;  // low address bits seen by the register decode

	//--------------------------------------------------
	// register offsets
	//--------------------------------------------------
	localparam logic [REG_OFS_W-1:0] REG_CHANNEL_ENABLE = 6'd0; // one bit per logical channel
	localparam logic [REG_OFS_W-1:0] REG_COH_DATA_READY = 6'd1; // set at end of coherent period
	localparam logic [REG_OFS_W-1:0] REG_STATE          = 6'd2; // current engine state, read only

endpackage

// ==== hdl/buffer_arbiter.sv ====
`timescale 1ns/100ps
// single port access to the state buffer
// fill/dump owns the port in FILL_STATE and DUMP_STATE, the host otherwise
module buffer_arbiter import te_reg_pkg::*; import te_ctrl_pkg::*; (
	input  te_state_t             i_state,
	input  logic                  i_buffer_cs,
	input  logic                  i_rd,
	input  logic                  i_wr,
	input  logic [TE_ADDR_W-1:0]  i_addr,
	input  logic [TE_DATA_W-1:0]  i_wdata,
	input  logic                  i_fd_rd,
	input  logic                  i_fd_wr,
	input  logic [BUF_ADDR_W-1:0] i_fd_addr,
	input  logic [TE_DATA_W-1:0]  i_fd_wdata,
	output logic                  o_en,
	output logic                  o_we,
	output logic [BUF_ADDR_W-1:0] o_addr,
	output logic [TE_DATA_W-1:0]  o_wdata
);

	logic fd_grant;
	logic host_rd;
	logic host_wr;

	assign fd_grant = (i_state == FILL_STATE) || (i_state == DUMP_STATE);
	assign host_rd  = i_buffer_cs && i_rd;
	assign host_wr  = i_buffer_cs && i_wr;

	// host cycles during fill and dump are simply lost
	assign o_en    = fd_grant ? (i_fd_rd || i_fd_wr) : (host_rd || host_wr);
	assign o_we    = fd_grant ? i_fd_wr : host_wr;
	assign o_addr  = fd_grant ? i_fd_addr : i_addr[BUF_ADDR_W-1:0];
	assign o_wdata = fd_grant ? i_fd_wdata : i_wdata;

endmodule

// ==== hdl/state_buffer.sv ====
`timescale 1ns/100ps
// single port channel state RAM, read data one cycle after the access
module state_buffer #(
	parameter int ADDR_W = 10,
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              i_en,
	input  logic              i_we,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata
);

	logic [DATA_W-1:0] mem [1 << ADDR_W];

	always_ff @(posedge clk) begin
		if (i_en) begin
			if (i_we)
				mem[i_addr] <= i_wdata;
			else
				o_rdata <= mem[i_addr]; // holds last read on writes
		end
	end

endmodule

// ==== hdl/te_regs.sv ====
`timescale 1ns/100ps
// host registers: channel enable, coherent data ready and state readback
// reads are combinational, writes land on the next clock edge
module te_regs import te_reg_pkg::*; import te_ctrl_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_te_reg_cs,
	input  logic                 i_te_rd,
	input  logic                 i_te_wr,
	input  logic [TE_ADDR_W-1:0] i_te_addr,
	input  logic [TE_DATA_W-1:0] i_te_d4wt,
	input  logic                 i_round_start,
	input  logic [TE_DATA_W-1:0] i_coh_set,
	input  te_state_t            i_state,
	output logic [TE_DATA_W-1:0] o_channel_enable,
	output logic                 o_te_ready,
	output logic [TE_DATA_W-1:0] o_te_reg_d4rd
);

	logic [TE_DATA_W-1:0] coh_ready;
	logic [REG_OFS_W-1:0] reg_ofs;
	logic                 reg_wr;

	assign reg_ofs = i_te_addr[REG_OFS_W-1:0];
	assign reg_wr  = i_te_reg_cs && i_te_wr;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_channel_enable <= '0;
			coh_ready        <= '0;
		end else begin
			if (reg_wr && (reg_ofs == REG_CHANNEL_ENABLE))
				o_channel_enable <= i_te_d4wt;
			if (reg_wr && (reg_ofs == REG_COH_DATA_READY))
				coh_ready <= i_te_d4wt;
			else if (i_round_start)
				coh_ready <= '0;              // fresh flags every round
			else
				coh_ready <= coh_ready | i_coh_set;
		end
	end

	assign o_te_ready = |coh_ready;

	always_comb begin
		o_te_reg_d4rd = '0;
		if (i_te_reg_cs && i_te_rd) begin
			case (reg_ofs)
				REG_CHANNEL_ENABLE: o_te_reg_d4rd = o_channel_enable;
				REG_COH_DATA_READY: o_te_reg_d4rd = coh_ready;
				REG_STATE:          o_te_reg_d4rd = TE_DATA_W'(i_state);
				default:            o_te_reg_d4rd = '0;
			endcase
		end
	end

endmodule

// ==== src.f ====
+incdir+tests
common/te_reg_pkg.sv
common/te_ctrl_pkg.sv
hdl/state_buffer.sv
hdl/buffer_arbiter.sv
hdl/te_regs.sv
tracking_engine/channel_accum.sv
tracking_engine/find_channel.sv
tracking_engine/fill_dump_ctrl.sv
tracking_engine/te_ctrl_fsm.sv
tracking_engine/tracking_engine.sv
tests/tb_tracking_engine.sv

// ==== tests/te_host_tasks.svh ====
// host side helpers for the tracking engine testbench: register and buffer access, LCG
// included inside the testbench module, drives its host signals on the falling edge
`ifndef TE_HOST_TASKS_SVH
`define TE_HOST_TASKS_SVH

logic [31:0] rng_state;

// LCG step, halves swapped so the low bits come from the better upper state bits
function automatic logic [31:0] rand_word();
	rng_state = rng_state * 32'd1664525 + 32'd1013904223;
	return {rng_state[15:0], rng_state[31:16]};
endfunction

// buffer address of one state word
function automatic logic [TE_ADDR_W-1:0] word_addr(input int ch,
		input logic [WORD_OFS_W-1:0] ofs);
	return {CH_IDX_W'(ch), ofs};
endfunction

task automatic reg_write(input logic [REG_OFS_W-1:0] ofs, input logic [TE_DATA_W-1:0] data);
	@(negedge clk);
	te_reg_cs = 1'b1;
	te_wr     = 1'b1;
	te_addr   = TE_ADDR_W'(ofs);
	te_d4wt   = data;
	@(negedge clk);
	te_reg_cs = 1'b0;
	te_wr     = 1'b0;
endtask

task automatic reg_read(input logic [REG_OFS_W-1:0] ofs, output logic [TE_DATA_W-1:0] data);
	@(negedge clk);
	te_reg_cs = 1'b1;
	te_rd     = 1'b1;
	te_addr   = TE_ADDR_W'(ofs);
	@(negedge clk);
	data      = reg_d4rd; // valid while rd is held
	te_reg_cs = 1'b0;
	te_rd     = 1'b0;
endtask

task automatic buf_write(input logic [TE_ADDR_W-1:0] addr, input logic [TE_DATA_W-1:0] data);
	@(negedge clk);
	te_buffer_cs = 1'b1;
	te_wr        = 1'b1;
	te_addr      = addr;
	te_d4wt      = data;
	@(negedge clk);
	te_buffer_cs = 1'b0;
	te_wr        = 1'b0;
endtask

task automatic buf_read(input logic [TE_ADDR_W-1:0] addr, output logic [TE_DATA_W-1:0] data);
	@(negedge clk);
	te_buffer_cs = 1'b1;
	te_rd        = 1'b1;
	te_addr      = addr;
	@(negedge clk);
	data         = rd_buffer; // RAM output one cycle after the read
	te_buffer_cs = 1'b0;
	te_rd        = 1'b0;
endtask

`endif

// ==== tests/tb_tracking_engine.sv ====
`timescale 1ns/100ps
// testbench of the tracking engine with FIFO model, host accesses and reference model
// runs an empty, a directed and several random rounds and checks the state buffer after each
module tb_tracking_engine import te_reg_pkg::*; import te_ctrl_pkg::*; ();

	localparam int BLK_LEN    = 16;
	localparam int NUM_ROUNDS = 6;  // empty, directed and four random rounds
	// up to 8 groups per round with at most block length plus 80 cycles each
	localparam int MAX_CYCLES = NUM_ROUNDS * (8 * (BLK_LEN + 80) + 300) + 1000;

	logic                 clk;
	logic                 rst_b;
	logic                 te_start;
	logic                 fifo_ready;
	logic                 fifo_last_data;
	logic                 fifo_data_valid;
	logic [7:0]           fifo_data;
	logic                 te_reg_cs;
	logic                 te_buffer_cs;
	logic                 te_rd;
	logic                 te_wr;
	logic [TE_ADDR_W-1:0] te_addr;
	logic [TE_DATA_W-1:0] te_d4wt;
	logic                 te_running, te_ready, te_over;
	logic                 fifo_read, fifo_rewind, fifo_skip;
	logic [TE_DATA_W-1:0] rd_buffer, reg_d4rd;

	logic [7:0]  block [BLK_LEN];  // current FIFO block
	int          fifo_pos;         // next sample or -1 when not streaming
	logic [31:0] ref_sum [NUM_LOGIC];
	logic [31:0] ref_count [NUM_LOGIC];
	logic [31:0] ref_target [NUM_LOGIC];
	logic [31:0] ref_result [NUM_LOGIC];
	logic [31:0] exp_ready;
	int          exp_groups;
	int          n_read, n_rewind, n_skip, n_over;
	int          errors = 0;
	int          cycles = 0;
	bit          check_req;
	string       round_name;

	`include "te_host_tasks.svh"

	tracking_engine #(.NUM_PHY(4)) dut (
		.clk(clk), .rst_b(rst_b), .i_te_start(te_start), .o_te_running(te_running),
		.o_te_ready(te_ready), .o_te_over(te_over), .i_fifo_ready(fifo_ready),
		.i_fifo_last_data(fifo_last_data), .o_fifo_read(fifo_read),
		.o_fifo_rewind(fifo_rewind), .o_fifo_skip(fifo_skip),
		.i_fifo_data_valid(fifo_data_valid), .i_fifo_data(fifo_data),
		.i_te_reg_cs(te_reg_cs), .i_te_buffer_cs(te_buffer_cs), .i_te_rd(te_rd),
		.i_te_wr(te_wr), .i_te_addr(te_addr), .i_te_d4wt(te_d4wt),
		.o_te_rd_buffer(rd_buffer), .o_te_reg_d4rd(reg_d4rd)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: test did not end within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic report_mismatch(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR %s: expected 0x%08h, got 0x%08h", test, exp, act);
		errors = errors + 1;
	endtask

	function automatic void new_block();
		logic [31:0] tmp;
		for (int i = 0; i < BLK_LEN; i++) begin
			tmp      = rand_word();
			block[i] = tmp[7:0];
		end
	endfunction

	function automatic logic [31:0] block_sum();
		logic [31:0] s;
		s = '0;
		for (int i = 0; i < BLK_LEN; i++)
			s = s + {{24{block[i][7]}}, block[i]}; // signed samples
		return s;
	endfunction

	// reference for one channel and one block that returns 1 when the period completes
	function automatic bit ref_update(input int ch, input logic [31:0] bsum);
		logic [31:0] teff;
		logic [31:0] cnt;
		teff        = (ref_target[ch] == 0) ? 32'd1 : ref_target[ch];
		cnt         = ref_count[ch] + 1;
		ref_sum[ch] = ref_sum[ch] + bsum;
		if (cnt >= teff) begin
			ref_result[ch] = ref_sum[ch];
			ref_sum[ch]    = '0;
			ref_count[ch]  = '0;
			return 1'b1;
		end
		ref_count[ch] = cnt;
		return 1'b0;
	endfunction

	//--------------------------------------------------
	// FIFO model and strobe counters
	//--------------------------------------------------
	always @(negedge clk) begin
		fifo_data_valid = 1'b0;
		fifo_last_data  = 1'b0;
		if (fifo_pos >= 0) begin
			fifo_data       = block[fifo_pos];
			fifo_data_valid = 1'b1;
			fifo_last_data  = (fifo_pos == BLK_LEN - 1);
			fifo_pos        = fifo_last_data ? -1 : fifo_pos + 1;
		end
		if (fifo_read)
			fifo_pos = 0;    // streaming starts one cycle after the strobe
		if (fifo_rewind)
			fifo_pos = -1;   // same block for the next group
		if (fifo_skip)
			new_block();
	end

	always @(negedge clk) begin
		if (fifo_read)
			n_read = n_read + 1;
		if (fifo_rewind)
			n_rewind = n_rewind + 1;
		if (fifo_skip)
			n_skip = n_skip + 1;
		if (te_over)
			n_over = n_over + 1;
	end

	task automatic run_round(input string name, input logic [31:0] en);
		logic [31:0] bsum;
		reg_write(REG_CHANNEL_ENABLE, en);
		bsum      = block_sum();
		exp_ready = '0;
		for (int ch = 0; ch < NUM_LOGIC; ch++) begin
			if (en[ch]) begin
				if (ref_update(ch, bsum))
					exp_ready[ch] = 1'b1;
			end
		end
		exp_groups = ($countones(en) + 3) / 4;
		n_read     = 0;
		n_rewind   = 0;
		n_skip     = 0;
		n_over     = 0;
		round_name = name;
		@(negedge clk);
		te_start = 1'b1;
		@(negedge clk);
		te_start = 1'b0;
		while (te_over !== 1'b1)
			@(negedge clk);
		@(negedge clk);  // engine now waits for the host
		check_req = 1'b1;
		wait (check_req == 1'b0);
	endtask

	// compares strobes, ready flags and every channel's state words after a round
	initial begin : compare
		logic [31:0] rd;
		int          exp_rewinds;
		forever begin
			wait (check_req == 1'b1);
			exp_rewinds = (exp_groups > 0) ? exp_groups - 1 : 0;
			if (n_read != exp_groups)
				report_mismatch({round_name, " fifo reads"}, exp_groups, n_read);
			if (n_rewind != exp_rewinds)
				report_mismatch({round_name, " fifo rewinds"}, exp_rewinds, n_rewind);
			if (n_skip != 1)
				report_mismatch({round_name, " fifo skips"}, 1, n_skip);
			if (n_over != 1)
				report_mismatch({round_name, " te_over pulses"}, 1, n_over);
			reg_read(REG_COH_DATA_READY, rd);
			if (rd !== exp_ready)
				report_mismatch({round_name, " ready register"}, exp_ready, rd);
			if (te_ready !== (|exp_ready))
				report_mismatch({round_name, " o_te_ready"}, |exp_ready, te_ready);
			for (int ch = 0; ch < NUM_LOGIC; ch++) begin
				buf_read(word_addr(ch, WORD_SUM), rd);
				if (rd !== ref_sum[ch])
					report_mismatch($sformatf("%s ch%0d sum", round_name, ch), ref_sum[ch], rd);
				buf_read(word_addr(ch, WORD_COUNT), rd);
				if (rd !== ref_count[ch])
					report_mismatch($sformatf("%s ch%0d count", round_name, ch), ref_count[ch], rd);
				buf_read(word_addr(ch, WORD_RESULT), rd);
				if (rd !== ref_result[ch])
					report_mismatch($sformatf("%s ch%0d result", round_name, ch), ref_result[ch], rd);
			end
			check_req = 1'b0;
		end
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] tmp;
		logic [31:0] en;
		rst_b           = 1'b0;
		te_start        = 1'b0;
		fifo_ready      = 1'b1; // a block is always waiting
		fifo_last_data  = 1'b0;
		fifo_data_valid = 1'b0;
		fifo_data       = 8'h00;
		te_reg_cs       = 1'b0;
		te_buffer_cs    = 1'b0;
		te_rd           = 1'b0;
		te_wr           = 1'b0;
		te_addr         = '0;
		te_d4wt         = '0;
		fifo_pos        = -1;
		rng_state       = 32'd71;
		new_block();
		repeat (8) @(negedge clk);
		rst_b = 1'b1;
		@(negedge clk);

		if (te_running !== 1'b0)
			report_mismatch("reset o_te_running", 0, te_running);
		if (te_over !== 1'b0)
			report_mismatch("reset o_te_over", 0, te_over);
		if (te_ready !== 1'b0)
			report_mismatch("reset o_te_ready", 0, te_ready);
		if ({fifo_read, fifo_rewind, fifo_skip} !== 3'b000)
			report_mismatch("reset fifo strobes", 0, {fifo_read, fifo_rewind, fifo_skip});
		reg_read(REG_CHANNEL_ENABLE, rd);
		if (rd !== 32'd0)
			report_mismatch("reset channel enable", 0, rd);

		// host buffer access while the engine is idle
		buf_write(10'h3FF, 32'hC0DE_5A17);
		buf_write(10'h3FE, 32'h1234_8765);
		buf_read(10'h3FF, rd);
		if (rd !== 32'hC0DE_5A17)
			report_mismatch("buffer readback 3ff", 32'hC0DE_5A17, rd);
		buf_read(10'h3FE, rd);
		if (rd !== 32'h1234_8765)
			report_mismatch("buffer readback 3fe", 32'h1234_8765, rd);

		// start state of all channels with targets of 0..3 blocks
		for (int ch = 0; ch < NUM_LOGIC; ch++) begin
			tmp            = rand_word();
			ref_sum[ch]    = '0;
			ref_count[ch]  = '0;
			ref_result[ch] = '0;
			ref_target[ch] = {30'd0, tmp[1:0]};
			buf_write(word_addr(ch, WORD_SUM), '0);
			buf_write(word_addr(ch, WORD_COUNT), '0);
			buf_write(word_addr(ch, WORD_TARGET), ref_target[ch]);
			buf_write(word_addr(ch, WORD_RESULT), '0);
		end

		reg_write(REG_COH_DATA_READY, 32'h0000_A5A5);
		reg_read(REG_COH_DATA_READY, rd);
		if (rd !== 32'h0000_A5A5)
			report_mismatch("ready register write", 32'h0000_A5A5, rd);
		if (te_ready !== 1'b1)
			report_mismatch("ready register write o_te_ready", 1, te_ready);

		run_round("empty round", 32'd0);           // also clears the written flags
		run_round("directed round", 32'h8001_0431); // six channels in two groups
		for (int r = 0; r < NUM_ROUNDS - 2; r++) begin
			en = rand_word() & rand_word();
			if ($countones(en) <= 4)
				en = en | 32'hF0F0_0000;
			run_round($sformatf("random round %0d", r), en);
		end

		$display("test done: %0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== tracking_engine/channel_accum.sv ====
`timescale 1ns/100ps
// one physical correlator slot, reduced to a signed sample accumulator
// state words come in from fill, updated words go out to dump
module channel_accum import te_reg_pkg::*; import te_ctrl_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_load_sel,
	input  logic [1:0]           i_load_word,
	input  logic [TE_DATA_W-1:0] i_load_data,
	input  logic                 i_accum_en,
	input  logic [7:0]           i_sample,
	output logic                 o_coh_done,
	output logic [TE_DATA_W-1:0] o_new_sum,
	output logic [TE_DATA_W-1:0] o_new_count,
	output logic [TE_DATA_W-1:0] o_result
);

	logic [TE_DATA_W-1:0] sum;
	logic [TE_DATA_W-1:0] count;      // blocks done in current period
	logic [TE_DATA_W-1:0] target;
	logic [TE_DATA_W-1:0] target_eff;
	logic [TE_DATA_W-1:0] count_inc;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			sum    <= '0;
			count  <= '0;
			target <= '0;
		end else if (i_load_sel) begin
			case (i_load_word)
				WORD_SUM[1:0]:    sum    <= i_load_data;
				WORD_COUNT[1:0]:  count  <= i_load_data;
				WORD_TARGET[1:0]: target <= i_load_data;
				default: ;
			endcase
		end else if (i_accum_en) begin
			sum <= sum + {{(TE_DATA_W - 8){i_sample[7]}}, i_sample};
		end
	end

	assign count_inc  = count + 1'b1;
	assign target_eff = (target == '0) ? TE_DATA_W'(1) : target; // zero means every block
	assign o_coh_done = (count_inc >= target_eff);

	assign o_new_sum   = o_coh_done ? '0 : sum;
	assign o_new_count = o_coh_done ? '0 : count_inc;
	assign o_result    = sum;

endmodule

// ==== tracking_engine/fill_dump_ctrl.sv ====
`timescale 1ns/100ps
// moves channel state between the state buffer and the physical slots
// fill reads three words per active slot, dump writes two or three back
module fill_dump_ctrl import te_reg_pkg::*; import te_ctrl_pkg::*; #(
	parameter int NUM_PHY = 4
) (
	input  logic                  clk,
	input  logic                  rst_b,
	input  logic                  i_fill_start,
	input  logic                  i_dump_start,
	input  logic [NUM_PHY-1:0]    i_phy_en,
	input  logic [CH_IDX_W-1:0]   i_logic_idx [NUM_PHY],
	input  logic [TE_DATA_W-1:0]  i_rdata,
	input  logic [NUM_PHY-1:0]    i_coh_done,
	input  logic [TE_DATA_W-1:0]  i_new_sum [NUM_PHY],
	input  logic [TE_DATA_W-1:0]  i_new_count [NUM_PHY],
	input  logic [TE_DATA_W-1:0]  i_result [NUM_PHY],
	output logic                  o_fill_done,
	output logic                  o_dump_done,
	output logic [NUM_PHY-1:0]    o_load_sel,
	output logic [1:0]            o_load_word,
	output logic                  o_rd,
	output logic                  o_wr,
	output logic [BUF_ADDR_W-1:0] o_addr,
	output logic [TE_DATA_W-1:0]  o_wdata,
	output logic [NUM_LOGIC-1:0]  o_coh_set
);

	localparam int SLOT_W = (NUM_PHY > 1) ? $clog2(NUM_PHY) : 1;

	logic                  busy;
	logic                  dump_mode;
	logic [SLOT_W-1:0]     slot;
	logic [1:0]            word;
	logic                  rd_d;      // read data returns this cycle
	logic [SLOT_W-1:0]     slot_d;
	logic [NUM_PHY-1:0]    phy_next;
	logic                  word_last;
	logic                  slot_last;
	logic                  step_last;
	logic [WORD_OFS_W-1:0] ofs;
	logic [TE_DATA_W-1:0]  dump_data;

	assign phy_next  = i_phy_en >> 1;                // active slots form a prefix
	assign word_last = (word == 2'd2) || (dump_mode && (word == 2'd1) && !i_coh_done[slot]);
	assign slot_last = !phy_next[slot];
	assign step_last = busy && word_last && slot_last;

	always_comb begin
		case (word)
			2'd0: begin
				ofs       = WORD_SUM;
				dump_data = i_new_sum[slot];
			end
			2'd1: begin
				ofs       = WORD_COUNT;
				dump_data = i_new_count[slot];
			end
			default: begin
				ofs       = dump_mode ? WORD_RESULT : WORD_TARGET;
				dump_data = i_result[slot];
			end
		endcase
	end

	assign o_rd       = busy && !dump_mode;
	assign o_wr       = busy && dump_mode;
	assign o_addr     = {i_logic_idx[slot], ofs};
	assign o_wdata    = rd_d ? i_rdata : dump_data;  // shared slot data bus
	assign o_load_sel = rd_d ? (NUM_PHY'(1) << slot_d) : '0;
	assign o_coh_set  = (o_wr && (word == 2'd2)) ? (NUM_LOGIC'(1) << i_logic_idx[slot]) : '0;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			busy        <= 1'b0;
			dump_mode   <= 1'b0;
			slot        <= '0;
			word        <= '0;
			rd_d        <= 1'b0;
			slot_d      <= '0;
			o_load_word <= '0;
			o_fill_done <= 1'b0;
			o_dump_done <= 1'b0;
		end else begin
			rd_d        <= o_rd;
			slot_d      <= slot;
			o_load_word <= word;
			o_fill_done <= (i_fill_start && !i_phy_en[0]) || (o_rd && step_last);
			o_dump_done <= (i_dump_start && !i_phy_en[0]) || (o_wr && step_last);
			if (i_fill_start || i_dump_start) begin
				busy      <= i_phy_en[0];
				dump_mode <= i_dump_start;
				slot      <= '0;
				word      <= '0;
			end else if (busy) begin
				if (word_last) begin
					word <= '0;
					slot <= slot + 1'b1;
					busy <= !slot_last;
				end else begin
					word <= word + 1'b1;
				end
			end
		end
	end

endmodule

// ==== tracking_engine/find_channel.sv ====
`timescale 1ns/100ps
// picks the next group of enabled logical channels for the physical slots
// scans one channel per cycle from bit 0, slots are filled from slot 0 up
module find_channel import te_ctrl_pkg::*; #(
	parameter int NUM_PHY = 4
) (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_latch,
	input  logic                 i_start,
	input  logic [NUM_LOGIC-1:0] i_channel_enable,
	output logic                 o_done,
	output logic                 o_channels_left,
	output logic [NUM_PHY-1:0]   o_phy_en,
	output logic [CH_IDX_W-1:0]  o_logic_idx [NUM_PHY]
);

	localparam int SLOT_W = (NUM_PHY > 1) ? $clog2(NUM_PHY) : 1;

	logic [NUM_LOGIC-1:0] remain; // channels not yet served this round
	logic                 busy;
	logic [CH_IDX_W-1:0]  scan;
	logic [SLOT_W-1:0]    slot;
	logic                 hit;
	logic                 finish;

	assign hit    = busy && remain[scan];
	assign finish = busy && ((scan == CH_IDX_W'(NUM_LOGIC - 1)) ||
	                         (hit && (slot == SLOT_W'(NUM_PHY - 1))));
	assign o_channels_left = |remain;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			remain   <= '0;
			busy     <= 1'b0;
			scan     <= '0;
			slot     <= '0;
			o_phy_en <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= finish;
			if (i_latch)
				remain <= i_channel_enable;
			else if (hit)
				remain[scan] <= 1'b0;
			if (i_start) begin
				busy     <= 1'b1;
				scan     <= '0;
				slot     <= '0;
				o_phy_en <= '0;
			end else if (busy) begin
				scan <= scan + 1'b1;
				if (hit) begin
					o_phy_en[slot] <= 1'b1;
					slot           <= slot + 1'b1;
				end
				if (finish)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit)
			o_logic_idx[slot] <= scan;
	end

endmodule

// ==== tracking_engine/te_ctrl_fsm.sv ====
`timescale 1ns/100ps
// round sequencer of the tracking engine
// issues block start pulses and the registered FIFO strobes
module te_ctrl_fsm import te_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	input  logic      i_te_start,
	input  logic      i_fifo_ready,
	input  logic      i_fifo_last_data,
	input  logic      i_any_enabled,
	input  logic      i_find_done,
	input  logic      i_fill_done,
	input  logic      i_dump_done,
	input  logic      i_channels_left,
	output te_state_t o_state,
	output logic      o_round_start,
	output logic      o_find_start,
	output logic      o_fill_start,
	output logic      o_dump_start,
	output logic      o_te_over,
	output logic      o_te_running,
	output logic      o_fifo_read,
	output logic      o_fifo_rewind,
	output logic      o_fifo_skip
);

	te_state_t           cur_state;
	te_state_t           nxt_state;
	logic [COR_TAIL-1:0] last_dly; // correlator drain after last sample
	logic                cor_done;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cur_state <= STAND_BY;
			last_dly  <= '0;
		end else begin
			cur_state <= nxt_state;
			last_dly  <= {last_dly[COR_TAIL-2:0], i_fifo_last_data};
		end
	end

	assign cor_done = last_dly[COR_TAIL-1];

	always_comb begin
		case (cur_state)
			STAND_BY:     nxt_state = i_te_start ? IDLE : STAND_BY;
			IDLE:         nxt_state = i_fifo_ready ? START : IDLE;
			START:        nxt_state = i_any_enabled ? FIND_CHANNEL : TE_FINISH;
			FIND_CHANNEL: nxt_state = i_find_done ? FILL_STATE : FIND_CHANNEL;
			FILL_STATE:   nxt_state = i_fill_done ? READ_FIFO : FILL_STATE;
			READ_FIFO:    nxt_state = CORRELATION;
			CORRELATION:  nxt_state = cor_done ? DUMP_STATE : CORRELATION;
			DUMP_STATE:   nxt_state = i_dump_done ? COR_FINISH : DUMP_STATE;
			COR_FINISH:   nxt_state = i_channels_left ? FIND_CHANNEL : TE_FINISH;
			TE_FINISH:    nxt_state = WAIT_CPU;
			WAIT_CPU:     nxt_state = i_te_start ? IDLE : WAIT_CPU;
			default:      nxt_state = STAND_BY;
		endcase
	end

	assign o_state       = cur_state;
	assign o_round_start = (nxt_state == START);
	assign o_find_start  = (cur_state != FIND_CHANNEL) && (nxt_state == FIND_CHANNEL);
	assign o_fill_start  = (cur_state == FIND_CHANNEL) && i_find_done;
	assign o_dump_start  = (cur_state == CORRELATION) && cor_done;
	assign o_te_over     = (cur_state == TE_FINISH);
	assign o_te_running  = (cur_state != STAND_BY) && (cur_state != WAIT_CPU);

	//--------------------------------------------------
	// FIFO strobes, one cycle each
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_fifo_read   <= 1'b0;
			o_fifo_rewind <= 1'b0;
			o_fifo_skip   <= 1'b0;
		end else begin
			o_fifo_read   <= (nxt_state == READ_FIFO);
			o_fifo_rewind <= (nxt_state == COR_FINISH) && i_channels_left; // same block again
			o_fifo_skip   <= (nxt_state == TE_FINISH);                     // block done for all
		end
	end

endmodule

// ==== tracking_engine/tracking_engine.sv ====
`timescale 1ns/100ps
// tracking engine top, time shares NUM_PHY slots among 32 logical channels
// connects registers, sequencer, channel search, fill/dump, slots and state RAM
module tracking_engine import te_reg_pkg::*; import te_ctrl_pkg::*; #(
	parameter int NUM_PHY = 4
) (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_te_start,
	output logic                 o_te_running,
	output logic                 o_te_ready,
	output logic                 o_te_over,
	input  logic                 i_fifo_ready,
	input  logic                 i_fifo_last_data,
	output logic                 o_fifo_read,
	output logic                 o_fifo_rewind,
	output logic                 o_fifo_skip,
	input  logic                 i_fifo_data_valid,
	input  logic [7:0]           i_fifo_data,
	input  logic                 i_te_reg_cs,
	input  logic                 i_te_buffer_cs,
	input  logic                 i_te_rd,
	input  logic                 i_te_wr,
	input  logic [TE_ADDR_W-1:0] i_te_addr,
	input  logic [TE_DATA_W-1:0] i_te_d4wt,
	output logic [TE_DATA_W-1:0] o_te_rd_buffer,
	output logic [TE_DATA_W-1:0] o_te_reg_d4rd
);

	te_state_t             state;
	logic [TE_DATA_W-1:0]  channel_enable;
	logic [NUM_LOGIC-1:0]  coh_set;
	logic                  round_start, find_start, fill_start, dump_start;
	logic                  find_done, fill_done, dump_done, channels_left;
	logic [NUM_PHY-1:0]    phy_en;
	logic [CH_IDX_W-1:0]   logic_idx [NUM_PHY];
	logic [NUM_PHY-1:0]    load_sel, coh_done;
	logic [1:0]            load_word;
	logic [TE_DATA_W-1:0]  new_sum [NUM_PHY];
	logic [TE_DATA_W-1:0]  new_count [NUM_PHY];
	logic [TE_DATA_W-1:0]  result [NUM_PHY];
	logic                  fd_rd, fd_wr, ram_en, ram_we, accum_en;
	logic [BUF_ADDR_W-1:0] fd_addr, ram_addr;
	logic [TE_DATA_W-1:0]  fd_wdata, ram_wdata;

	assign accum_en = i_fifo_data_valid && (state == CORRELATION);

	te_regs u_regs (
		.clk(clk), .rst_b(rst_b), .i_te_reg_cs(i_te_reg_cs), .i_te_rd(i_te_rd),
		.i_te_wr(i_te_wr), .i_te_addr(i_te_addr), .i_te_d4wt(i_te_d4wt),
		.i_round_start(round_start), .i_coh_set(coh_set), .i_state(state),
		.o_channel_enable(channel_enable), .o_te_ready(o_te_ready), .o_te_reg_d4rd(o_te_reg_d4rd)
	);

	te_ctrl_fsm u_fsm (
		.clk(clk), .rst_b(rst_b), .i_te_start(i_te_start), .i_fifo_ready(i_fifo_ready),
		.i_fifo_last_data(i_fifo_last_data), .i_any_enabled(|channel_enable),
		.i_find_done(find_done), .i_fill_done(fill_done), .i_dump_done(dump_done),
		.i_channels_left(channels_left), .o_state(state), .o_round_start(round_start),
		.o_find_start(find_start), .o_fill_start(fill_start), .o_dump_start(dump_start),
		.o_te_over(o_te_over), .o_te_running(o_te_running), .o_fifo_read(o_fifo_read),
		.o_fifo_rewind(o_fifo_rewind), .o_fifo_skip(o_fifo_skip)
	);

	find_channel #(.NUM_PHY(NUM_PHY)) u_find (
		.clk(clk), .rst_b(rst_b), .i_latch(round_start), .i_start(find_start),
		.i_channel_enable(channel_enable), .o_done(find_done), .o_channels_left(channels_left),
		.o_phy_en(phy_en), .o_logic_idx(logic_idx)
	);

	//--------------------------------------------------
	// state transfer and slots
	//--------------------------------------------------
	fill_dump_ctrl #(.NUM_PHY(NUM_PHY)) u_fill_dump (
		.clk(clk), .rst_b(rst_b), .i_fill_start(fill_start), .i_dump_start(dump_start),
		.i_phy_en(phy_en), .i_logic_idx(logic_idx), .i_rdata(o_te_rd_buffer),
		.i_coh_done(coh_done), .i_new_sum(new_sum), .i_new_count(new_count), .i_result(result),
		.o_fill_done(fill_done), .o_dump_done(dump_done), .o_load_sel(load_sel),
		.o_load_word(load_word), .o_rd(fd_rd), .o_wr(fd_wr), .o_addr(fd_addr),
		.o_wdata(fd_wdata), .o_coh_set(coh_set)
	);

	for (genvar i = 0; i < NUM_PHY; i++) begin : g_slot
		channel_accum u_accum (
			.clk(clk), .rst_b(rst_b), .i_load_sel(load_sel[i]), .i_load_word(load_word),
			.i_load_data(fd_wdata), .i_accum_en(accum_en), .i_sample(i_fifo_data),
			.o_coh_done(coh_done[i]), .o_new_sum(new_sum[i]), .o_new_count(new_count[i]),
			.o_result(result[i])
		);
	end

	buffer_arbiter u_arbiter (
		.i_state(state), .i_buffer_cs(i_te_buffer_cs), .i_rd(i_te_rd), .i_wr(i_te_wr),
		.i_addr(i_te_addr), .i_wdata(i_te_d4wt), .i_fd_rd(fd_rd), .i_fd_wr(fd_wr),
		.i_fd_addr(fd_addr), .i_fd_wdata(fd_wdata), .o_en(ram_en), .o_we(ram_we),
		.o_addr(ram_addr), .o_wdata(ram_wdata)
	);

	state_buffer #(.ADDR_W(BUF_ADDR_W), .DATA_W(TE_DATA_W)) u_state_buffer (
		.clk(clk), .i_en(ram_en), .i_we(ram_we), .i_addr(ram_addr),
		.i_wdata(ram_wdata), .o_rdata(o_te_rd_buffer)
	);

endmodule
